// File: llc_cfg_pkg.sv
// Cache geometry for the LLC tag store, imported by every RTL block of the store
`default_nettype none

package llc_cfg_pkg;

  // ------------------------------------------------------------------------
  // Base geometry
  // ------------------------------------------------------------------------

  // Ways per set
  localparam int unsigned NumWays = 4;

  // Sets in the cache, one tag memory row each
  localparam int unsigned NumSets = 16;

  // Stored tag bits per line
  localparam int unsigned TagWidth = 8;

  // ------------------------------------------------------------------------
  // Derived widths
  // ------------------------------------------------------------------------

  // Set index doubles as the row address of each way memory
  localparam int unsigned IndexWidth = $clog2(NumSets);

  // Binary way number, used for the victim pointer and line selection
  localparam int unsigned WayIdxWidth = $clog2(NumWays);

endpackage

`default_nettype wire

// File: llc_tag_pkg.sv
// Request, response and stored-line types shared by the tag store blocks and its testbench
`default_nettype none

package llc_tag_pkg;

  import llc_cfg_pkg::*;

  // ------------------------------------------------------------------------
  // Basic fields
  // ------------------------------------------------------------------------

  // One bit per way, used for allowed masks and one-hot way selects
  typedef logic [NumWays-1:0] way_mask_t;

  // Set index
  typedef logic [IndexWidth-1:0] index_t;

  // Tag of a line
  typedef logic [TagWidth-1:0] tag_t;

  // Request modes
  typedef enum logic {
    MODE_LOOKUP = 1'b0,
    MODE_FLUSH  = 1'b1
  } tag_mode_e;

  // Controller FSM states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_READ  = 2'd1,
    ST_RESP  = 2'd2,
    ST_WRITE = 2'd3
  } ctrl_state_e;

  // ------------------------------------------------------------------------
  // Structs
  // ------------------------------------------------------------------------

  // Line as held in one way: valid flop plus dirty/tag memory
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_line_t;

  // Request; way is the allowed mask on lookup, the one-hot target on flush
  typedef struct packed {
    tag_mode_e mode;
    way_mask_t way;
    index_t    index;
    tag_t      tag;
    logic      dirty;
  } tag_req_t;

  // Response; way is one-hot, evict_tag only meaningful with evict set
  typedef struct packed {
    way_mask_t way;
    logic      hit;
    logic      evict;
    tag_t      evict_tag;
  } tag_res_t;

endpackage

`default_nettype wire

// File: tag_way.sv
// One way of the tag store with valid flops, tag/dirty memory and tag compare
`timescale 1ns/1ps
`default_nettype none

module tag_way (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  llc_tag_pkg::index_t    index_i,
  input  llc_tag_pkg::tag_line_t wdata_i,
  input  llc_tag_pkg::tag_t      cmp_tag_i,
  output llc_tag_pkg::tag_line_t rdata_o,
  output logic                   hit_o,
  output logic                   rvalid_o
);

  import llc_cfg_pkg::*;
  import llc_tag_pkg::*;

  // Valid bits per set, cleared at reset so a first lookup is defined
  logic [NumSets-1:0] valid_q;
  // Dirty and tag storage, no reset
  logic               dirty_mem [NumSets];
  tag_t               tag_mem   [NumSets];
  // Read port register, holds the last read until the next one
  tag_line_t          rd_line_q;
  logic               rvalid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_valid
    if (!arst_n_i) begin
      valid_q  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      if (req_i && we_i) begin
        valid_q[index_i] <= wdata_i.valid;
      end
      // One pulse per read, one cycle after the request
      rvalid_q <= req_i & ~we_i;
    end
  end

  always_ff @(posedge clk_i) begin : proc_mem
    if (req_i && we_i) begin
      dirty_mem[index_i] <= wdata_i.dirty;
      tag_mem[index_i]   <= wdata_i.tag;
    end
    // Writes leave the read register alone
    if (req_i && !we_i) begin
      rd_line_q.valid <= valid_q[index_i];
      rd_line_q.dirty <= dirty_mem[index_i];
      rd_line_q.tag   <= tag_mem[index_i];
    end
  end

  assign rdata_o  = rd_line_q;
  assign rvalid_o = rvalid_q;

  // Hit on a valid line with matching tag
  assign hit_o = rd_line_q.valid & (rd_line_q.tag == cmp_tag_i);

endmodule

`default_nettype wire

// File: victim_select.sv
// Picks the victim way on a lookup miss for the tag store controller
`timescale 1ns/1ps
`default_nettype none

module victim_select (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   sel_req_i,
  input  logic                   sel_take_i,
  input  llc_tag_pkg::way_mask_t allowed_i,
  input  llc_tag_pkg::way_mask_t valid_i,
  output llc_tag_pkg::way_mask_t victim_o
);

  import llc_cfg_pkg::*;
  import llc_tag_pkg::*;

  // Round robin pointer for sets whose allowed ways are all taken
  logic [WayIdxWidth-1:0] ptr_q;
  logic [WayIdxWidth-1:0] ptr_next;
  logic [WayIdxWidth-1:0] pick_idx;
  way_mask_t              free_way;
  logic                   set_full;

  always_comb begin : proc_pick
    int unsigned pos;
    pos      = 0;
    free_way = allowed_i & ~valid_i;
    set_full = ~|free_way;
    pick_idx = '0;
    if (!set_full) begin
      // Scan downwards so the lowest free way wins
      for (int i = NumWays - 1; i >= 0; i--) begin
        if (free_way[i]) begin
          pick_idx = WayIdxWidth'(i);
        end
      end
    end else begin
      // First allowed way at or after the pointer with wrap
      for (int i = NumWays - 1; i >= 0; i--) begin
        pos = (int'(ptr_q) + i) % NumWays;
        if (allowed_i[pos]) begin
          pick_idx = WayIdxWidth'(pos);
        end
      end
    end
  end

  // Pointer moves to the way after the chosen one
  assign ptr_next = (pick_idx == WayIdxWidth'(NumWays - 1)) ? '0 : pick_idx + 1'b1;

  // No victim without a request or with an empty mask
  assign victim_o = (sel_req_i && (|allowed_i)) ? (way_mask_t'(1) << pick_idx) : '0;

  // An empty mask chooses nothing and leaves the pointer where it is
  always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_ptr
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (sel_req_i && sel_take_i && set_full && (|allowed_i)) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

`default_nettype wire

// File: resp_spill.sv
// Two-entry spill register on the response path, cuts the path to the consumer
`timescale 1ns/1ps
`default_nettype none

module resp_spill (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  llc_tag_pkg::tag_res_t data_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output llc_tag_pkg::tag_res_t data_o
);

  import llc_tag_pkg::*;

  // ------------------------------------------------------------------------
  // Entry A takes new data, entry B catches A when the output stalls
  // ------------------------------------------------------------------------

  logic     a_full_q;
  logic     b_full_q;
  tag_res_t a_data_q;
  tag_res_t b_data_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  // Accept while at least one entry is free
  assign ready_o = ~a_full_q | ~b_full_q;

  assign a_fill  = valid_i & ready_o;
  // A leaves when B is empty, either to the output or into B
  assign a_drain = a_full_q & ~b_full_q;
  // A moves into B only if the consumer stalls
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_full
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin : proc_data
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // ------------------------------------------------------------------------
  // Output side
  // ------------------------------------------------------------------------

  // B is always older than A, so it goes first
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

`default_nettype wire

// File: tag_store_ctrl.sv
// Tag store FSM: reads the ways, builds the response, writes back once it is accepted
`timescale 1ns/1ps
`default_nettype none

module tag_store_ctrl (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  llc_tag_pkg::tag_req_t  req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  llc_tag_pkg::tag_line_t [llc_cfg_pkg::NumWays-1:0] line_i,
  input  llc_tag_pkg::way_mask_t hit_i,
  input  llc_tag_pkg::way_mask_t rvalid_i,
  output logic                   sel_req_o,
  output logic                   sel_take_o,
  output llc_tag_pkg::way_mask_t sel_allowed_o,
  output llc_tag_pkg::way_mask_t sel_valid_o,
  input  llc_tag_pkg::way_mask_t victim_i,
  output llc_tag_pkg::way_mask_t ram_req_o,
  output llc_tag_pkg::way_mask_t ram_we_o,
  output llc_tag_pkg::index_t    ram_index_o,
  output llc_tag_pkg::tag_line_t ram_wdata_o,
  output llc_tag_pkg::tag_t      cmp_tag_o,
  output logic                   res_valid_o,
  input  logic                   res_ready_i,
  output llc_tag_pkg::tag_res_t  res_o
);

  import llc_cfg_pkg::*;
  import llc_tag_pkg::*;

  ctrl_state_e            state_q;
  ctrl_state_e            state_d;
  // Accepted request
  tag_req_t               req_q;
  // Response side
  way_mask_t              hit_way;
  logic                   lookup_hit;
  way_mask_t              res_way;
  logic [WayIdxWidth-1:0] res_idx;
  tag_line_t              res_line;
  logic                   res_take;
  // Write-back, latched when the response is taken
  logic                   wr_en;
  tag_line_t              wr_line;
  way_mask_t              wr_way_q;
  tag_line_t              wr_line_q;

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------

  assign req_ready_o = (state_q == ST_IDLE);
  assign res_valid_o = (state_q == ST_RESP);
  assign res_take    = res_valid_o & res_ready_i;

  always_comb begin : proc_next_state
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (req_valid_i) begin
          state_d = ST_READ;
        end
      end
      // Wait until every read way has returned its line
      ST_READ: begin
        if ((rvalid_i & req_q.way) == req_q.way) begin
          state_d = ST_RESP;
        end
      end
      // Response held here while the spill stage is full
      ST_RESP: begin
        if (res_ready_i) begin
          state_d = ST_WRITE;
        end
      end
      ST_WRITE: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_state
    if (!arst_n_i) begin
      state_q  <= ST_IDLE;
      wr_way_q <= '0;
    end else begin
      state_q <= state_d;
      if (res_take) begin
        wr_way_q <= wr_en ? res_way : '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin : proc_payload
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
    if (res_take) begin
      wr_line_q <= wr_line;
    end
  end

  // ------------------------------------------------------------------------
  // Response
  // ------------------------------------------------------------------------

  // Ways outside the request hold stale read data
  assign hit_way    = hit_i & req_q.way;
  assign lookup_hit = (req_q.mode == MODE_LOOKUP) & (|hit_way);

  always_comb begin : proc_valid_vec
    for (int i = 0; i < NumWays; i++) begin
      sel_valid_o[i] = line_i[i].valid;
    end
  end

  assign sel_allowed_o = req_q.way;
  assign sel_req_o     = res_valid_o & (req_q.mode == MODE_LOOKUP) & ~(|hit_way);
  // Pointer only moves once the miss response is really gone
  assign sel_take_o    = sel_req_o & res_ready_i;

  always_comb begin : proc_res_way
    if (req_q.mode == MODE_FLUSH) begin
      res_way = req_q.way;
    end else if (lookup_hit) begin
      res_way = hit_way;
    end else begin
      res_way = victim_i;
    end
  end

  // One-hot to binary, lowest set bit
  always_comb begin : proc_res_idx
    res_idx = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (res_way[i]) begin
        res_idx = WayIdxWidth'(i);
      end
    end
  end

  assign res_line = line_i[res_idx];

  always_comb begin : proc_resp
    res_o     = '0;
    res_o.way = res_way;
    if (lookup_hit) begin
      res_o.hit = 1'b1;
    end else begin
      // Miss victim or flushed line, evict only if valid and dirty
      res_o.evict     = (|res_way) & res_line.valid & res_line.dirty;
      res_o.evict_tag = res_line.tag;
    end
  end

  // ------------------------------------------------------------------------
  // Write-back and memory port
  // ------------------------------------------------------------------------

  always_comb begin : proc_wr
    wr_en   = 1'b1;
    wr_line = '{valid: 1'b1, dirty: req_q.dirty, tag: req_q.tag};
    if (req_q.mode == MODE_FLUSH) begin
      wr_line = '0;
    end else if (lookup_hit) begin
      // Hit only writes when a clean line turns dirty
      wr_en         = req_q.dirty & ~res_line.dirty;
      wr_line.dirty = 1'b1;
    end
  end

  always_comb begin : proc_ram
    ram_req_o   = '0;
    ram_we_o    = '0;
    ram_index_o = req_q.index;
    if (state_q == ST_IDLE) begin
      // Read straight off the request on the accept edge
      ram_index_o = req_i.index;
      if (req_valid_i) begin
        ram_req_o = req_i.way;
      end
    end else if (state_q == ST_WRITE) begin
      ram_req_o = wr_way_q;
      ram_we_o  = wr_way_q;
    end
  end

  assign ram_wdata_o = wr_line_q;
  assign cmp_tag_o   = req_q.tag;

endmodule

`default_nettype wire

// File: llc_tag_store.sv
// Top of the LLC tag store, connects controller, ways, victim choice and output spill
`timescale 1ns/1ps
`default_nettype none

module llc_tag_store (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Request side
  input  llc_tag_pkg::tag_req_t req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Response side
  output llc_tag_pkg::tag_res_t res_o,
  output logic                  res_valid_o,
  input  logic                  res_ready_i
);

  import llc_cfg_pkg::*;
  import llc_tag_pkg::*;

  // ------------------------------------------------------------------------
  // Wires
  // ------------------------------------------------------------------------

  // Controller to ways, shared by all ways
  way_mask_t                 ram_req;
  way_mask_t                 ram_we;
  index_t                    ram_index;
  tag_line_t                 ram_wdata;
  tag_t                      cmp_tag;
  // Ways back to controller
  tag_line_t [NumWays-1:0]   way_line;
  way_mask_t                 way_hit;
  way_mask_t                 way_rvalid;
  // Victim choice
  logic                      sel_req;
  logic                      sel_take;
  way_mask_t                 sel_allowed;
  way_mask_t                 sel_valid;
  way_mask_t                 victim;
  // Controller into spill stage
  tag_res_t                  ctrl_res;
  logic                      ctrl_res_valid;
  logic                      ctrl_res_ready;

  tag_store_ctrl i_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .line_i        (way_line),
    .hit_i         (way_hit),
    .rvalid_i      (way_rvalid),
    .sel_req_o     (sel_req),
    .sel_take_o    (sel_take),
    .sel_allowed_o (sel_allowed),
    .sel_valid_o   (sel_valid),
    .victim_i      (victim),
    .ram_req_o     (ram_req),
    .ram_we_o      (ram_we),
    .ram_index_o   (ram_index),
    .ram_wdata_o   (ram_wdata),
    .cmp_tag_o     (cmp_tag),
    .res_valid_o   (ctrl_res_valid),
    .res_ready_i   (ctrl_res_ready),
    .res_o         (ctrl_res)
  );

  // One storage way per cache way
  for (genvar i = 0; i < NumWays; i++) begin : gen_way
    tag_way i_way (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .req_i     (ram_req[i]),
      .we_i      (ram_we[i]),
      .index_i   (ram_index),
      .wdata_i   (ram_wdata),
      .cmp_tag_i (cmp_tag),
      .rdata_o   (way_line[i]),
      .hit_o     (way_hit[i]),
      .rvalid_o  (way_rvalid[i])
    );
  end

  victim_select i_victim (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .sel_req_i  (sel_req),
    .sel_take_i (sel_take),
    .allowed_i  (sel_allowed),
    .valid_i    (sel_valid),
    .victim_o   (victim)
  );

  // Always in the path, no bypass
  resp_spill i_spill (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (ctrl_res_valid),
    .ready_o  (ctrl_res_ready),
    .data_i   (ctrl_res),
    .valid_o  (res_valid_o),
    .ready_i  (res_ready_i),
    .data_o   (res_o)
  );

endmodule

`default_nettype wire

// File: tb_tag_model.svh
// Reference model of the tag store, included in the body of the testbench module
`ifndef TB_TAG_MODEL_SVH
`define TB_TAG_MODEL_SVH

  // ------------------------------------------------------------------------
  // Model state
  // ------------------------------------------------------------------------

  // Line state per way and set
  logic        model_valid [NumWays][NumSets];
  logic        model_dirty [NumWays][NumSets];
  tag_t        model_tag   [NumWays][NumSets];
  // One round robin pointer for the whole store
  int unsigned model_ptr;

  // Empty store, as after reset
  function automatic void model_clear();
    for (int w = 0; w < NumWays; w++) begin
      for (int s = 0; s < NumSets; s++) begin
        model_valid[w][s] = 1'b0;
        model_dirty[w][s] = 1'b0;
        model_tag[w][s]   = '0;
      end
    end
    model_ptr = 0;
  endfunction

  // Expected response for one request, updates the model state
  function automatic tag_res_t predict_response(input tag_req_t r);
    tag_res_t res;
    int       hit_w;
    int       sel_w;
    int       w;
    res   = '0;
    hit_w = -1;
    sel_w = -1;
    if (r.mode == MODE_FLUSH) begin
      // Flush names one way
      for (int i = NumWays - 1; i >= 0; i--) begin
        if (r.way[i]) begin
          sel_w = i;
        end
      end
      if (sel_w >= 0) begin
        res.way       = r.way;
        res.evict     = model_valid[sel_w][r.index] & model_dirty[sel_w][r.index];
        res.evict_tag = model_tag[sel_w][r.index];
        model_valid[sel_w][r.index] = 1'b0;
        model_dirty[sel_w][r.index] = 1'b0;
      end
      return res;
    end
    // Lookup, hit only inside the allowed mask
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (r.way[i] && model_valid[i][r.index] && (model_tag[i][r.index] == r.tag)) begin
        hit_w = i;
      end
    end
    if (hit_w >= 0) begin
      res.way[hit_w] = 1'b1;
      res.hit        = 1'b1;
      if (r.dirty) begin
        model_dirty[hit_w][r.index] = 1'b1;
      end
      return res;
    end
    // Miss: lowest free allowed way first
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (r.way[i] && !model_valid[i][r.index]) begin
        sel_w = i;
      end
    end
    if (sel_w < 0) begin
      // Set full, round robin from the pointer
      for (int k = 0; k < NumWays; k++) begin
        w = (model_ptr + k) % NumWays;
        if (sel_w < 0 && r.way[w]) begin
          sel_w = w;
        end
      end
      if (sel_w >= 0) begin
        model_ptr = (sel_w + 1) % NumWays;
      end
    end
    if (sel_w >= 0) begin
      res.way[sel_w] = 1'b1;
      res.evict      = model_valid[sel_w][r.index] & model_dirty[sel_w][r.index];
      res.evict_tag  = model_tag[sel_w][r.index];
      model_valid[sel_w][r.index] = 1'b1;
      model_dirty[sel_w][r.index] = r.dirty;
      model_tag[sel_w][r.index]   = r.tag;
    end
    return res;
  endfunction

`endif

// File: tb_llc_tag_store.sv
// Testbench for the LLC tag store, compares every response with the included reference model
`timescale 1ns/1ps
`default_nettype none

module tb_llc_tag_store;

  import llc_cfg_pkg::*;
  import llc_tag_pkg::*;

  localparam int unsigned ClkPeriod   = 40;
  localparam int unsigned ResetCycles = 16;
  // Cycles any single wait may take
  localparam int unsigned WaitLimit   = 400;
  localparam int unsigned RandomReqs  = 300;

  logic        clk_i;
  logic        arst_n_i;
  tag_req_t    req_i;
  logic        req_valid_i;
  logic        req_ready_o;
  tag_res_t    res_o;
  logic        res_valid_o;
  logic        res_ready_i;

  // Stimulus and back-pressure draw from separate streams
  integer      seed;
  integer      ready_seed;
  logic        ready_random;
  string       test_name;
  int unsigned check_cnt;
  int unsigned error_cnt;
  int unsigned timeout_cnt;
  // Expected responses in request order, with the test that sent them
  tag_res_t    exp_queue [$];
  string       name_queue [$];

  `include "tb_tag_model.svh"

  llc_tag_store dut_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .res_o       (res_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, error_cnt, timeout_cnt);
    if (error_cnt == 0 && timeout_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // Ready is stable between edges, so seeing it at the falling edge fixes the transfer
  task automatic send_req(input tag_req_t r);
    int unsigned wait_cnt;
    wait_cnt = 0;
    @(negedge clk_i);
    req_i       = r;
    req_valid_i = 1'b1;
    while (!req_ready_o) begin
      @(negedge clk_i);
      wait_cnt++;
      if (wait_cnt > WaitLimit) begin
        $display("Timeout: request in %s was not accepted in time", test_name);
        timeout_cnt++;
        finish_run();
      end
    end
    exp_queue.push_back(predict_response(r));
    name_queue.push_back(test_name);
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic send_lookup(input index_t index, input way_mask_t mask, input tag_t tag,
                             input logic dirty);
    tag_req_t r;
    r       = '0;
    r.mode  = MODE_LOOKUP;
    r.way   = mask;
    r.index = index;
    r.tag   = tag;
    r.dirty = dirty;
    send_req(r);
  endtask

  task automatic send_flush(input index_t index, input way_mask_t way);
    tag_req_t r;
    r       = '0;
    r.mode  = MODE_FLUSH;
    r.way   = way;
    r.index = index;
    send_req(r);
  endtask

  // Small tag and set range so that hits and evictions are frequent
  function automatic tag_req_t random_req();
    tag_req_t    r;
    logic [31:0] rnd;
    rnd     = $random(seed);
    r       = '0;
    r.index = index_t'(rnd[1:0]);
    r.tag   = tag_t'(rnd[4:2]);
    r.dirty = rnd[5];
    if (rnd[8:6] == 3'd0) begin
      r.mode = MODE_FLUSH;
      r.way  = way_mask_t'(1) << rnd[10:9];
    end else begin
      r.mode = MODE_LOOKUP;
      r.way  = way_mask_t'(rnd[14:11]);
      if (r.way == '0) begin
        r.way = '1;
      end
      // Widen the mask so one tag never sits in two ways of a set
      for (int w = 0; w < NumWays; w++) begin
        if (model_valid[w][r.index] && (model_tag[w][r.index] == r.tag)) begin
          r.way[w] = 1'b1;
        end
      end
    end
    return r;
  endfunction

  task automatic wait_drain();
    int unsigned wait_cnt;
    wait_cnt = 0;
    while (exp_queue.size() != 0) begin
      @(negedge clk_i);
      wait_cnt++;
      if (wait_cnt > WaitLimit) begin
        $display("Timeout: %0d responses never arrived", exp_queue.size());
        timeout_cnt++;
        finish_run();
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // Consumer side: drives ready, compares each response that transfers
  // ------------------------------------------------------------------------

  always @(negedge clk_i) begin : proc_compare
    logic [31:0] rnd;
    tag_res_t    exp_res;
    string       exp_name;
    rnd = $random(ready_seed);
    if (ready_random) begin
      // Mostly stalled, so the spill stage fills up
      res_ready_i = (rnd[1:0] == 2'b00);
    end else begin
      res_ready_i = 1'b1;
    end
    if (arst_n_i && res_valid_o && res_ready_i) begin
      if (exp_queue.size() == 0) begin
        $display("Response arrived with no request outstanding, way %b", res_o.way);
        error_cnt++;
      end else begin
        exp_res  = exp_queue.pop_front();
        exp_name = name_queue.pop_front();
        check_value({exp_name, " way"}, 32'(exp_res.way), 32'(res_o.way));
        check_value({exp_name, " hit"}, 32'(exp_res.hit), 32'(res_o.hit));
        check_value({exp_name, " evict"}, 32'(exp_res.evict), 32'(res_o.evict));
        // Evict tag carries meaning only with evict set
        if (exp_res.evict) begin
          check_value({exp_name, " evict_tag"}, 32'(exp_res.evict_tag), 32'(res_o.evict_tag));
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------

  initial begin : proc_stim
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    req_i        = '0;
    req_valid_i  = 1'b0;
    res_ready_i  = 1'b0;
    seed         = 32'hf6f6bc0e;
    ready_seed   = ~seed;
    ready_random = 1'b0;
    check_cnt    = 0;
    error_cnt    = 0;
    timeout_cnt  = 0;
    model_clear();
    repeat (ResetCycles) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    test_name = "reset";
    check_value("reset req_ready", 32'd1, 32'(req_ready_o));
    check_value("reset res_valid", 32'd0, 32'(res_valid_o));

    // Empty sets miss into the lowest allowed way
    test_name = "empty_miss";
    send_lookup(4'd0, 4'b1100, 8'h11, 1'b0);
    send_lookup(4'd1, 4'b1111, 8'h22, 1'b0);
    send_lookup(4'd2, 4'b0010, 8'h23, 1'b1);

    // Hits, then a dirty hit seen by a later flush
    test_name = "hit_dirty";
    send_lookup(4'd0, 4'b1111, 8'h11, 1'b0);
    send_lookup(4'd0, 4'b1111, 8'h11, 1'b1);
    send_lookup(4'd0, 4'b0100, 8'h11, 1'b0);
    send_flush(4'd0, 4'b0100);

    // Fill a set, then keep missing
    test_name = "round_robin";
    for (int i = 0; i < 10; i++) begin
      send_lookup(4'd3, 4'b1111, tag_t'(8'h30 + i), i[0]);
    end
    for (int i = 0; i < 4; i++) begin
      send_lookup(4'd3, 4'b0110, tag_t'(8'h50 + i), 1'b1);
    end

    test_name = "flush_evict";
    send_lookup(4'd5, 4'b0001, 8'h55, 1'b1);
    send_flush(4'd5, 4'b0001);
    send_lookup(4'd5, 4'b1111, 8'h55, 1'b0);
    // Never written line
    send_flush(4'd5, 4'b1000);
    wait_drain();

    test_name    = "random_mix";
    ready_random = 1'b1;
    repeat (RandomReqs) begin
      send_req(random_req());
    end
    wait_drain();
    ready_random = 1'b0;
    // Room for a stray response to show up
    repeat (10) @(negedge clk_i);
    finish_run();
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
llc_cfg_pkg.sv
llc_tag_pkg.sv
tag_way.sv
victim_select.sv
resp_spill.sv
tag_store_ctrl.sv
llc_tag_store.sv
tb_llc_tag_store.sv

// File: Bender.yml
package:
  name: llc_tag_store

sources:
  - llc_cfg_pkg.sv
  - llc_tag_pkg.sv
  - tag_way.sv
  - victim_select.sv
  - resp_spill.sv
  - tag_store_ctrl.sv
  - llc_tag_store.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_llc_tag_store.sv
